//--- hw/dmr_macros.svh
//**************************************************************************
// DMR supervisor build constants
// Group count, bus and counter widths and restore window length, shared
// by the packages and the RTL of the DMR supervisor
//**************************************************************************

`ifndef DMR_MACROS_SVH
`define DMR_MACROS_SVH

// Number of core pairs under supervision
`define DMR_NUM_GROUPS 4

// Data field width of one core output bus
`define DMR_DATA_W 32

// Width of a saturating mismatch counter
`define DMR_CNT_W 8

// Length of one hardware restore window in cycles
`define DMR_RESTORE_CYCLES 6

`endif

//--- hw/dmr_reg_pkg.sv
//**************************************************************************
// DMR supervisor register interface types
// Strobe request and response structs and the word address map of the
// control register bank
//**************************************************************************

package dmr_reg_pkg;

  // Word addresses of the register bank
  typedef enum logic [3:0] {
    ADDR_ENABLE    = 4'd0,
    ADDR_RAPID     = 4'd1,
    ADDR_FORCE     = 4'd2,
    ADDR_STATUS    = 4'd3,
    ADDR_MISMATCH0 = 4'd4,
    ADDR_MISMATCH1 = 4'd5,
    ADDR_MISMATCH2 = 4'd6,
    ADDR_MISMATCH3 = 4'd7
  } reg_addr_e;

  typedef struct packed {
    logic        valid;
    logic        write;
    reg_addr_e   addr;
    logic [31:0] wdata;
  } reg_req_t;

  // Err flags an access to an unmapped address
  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } reg_rsp_t;

endpackage

//--- hw/dmr_core_pkg.sv
//**************************************************************************
// DMR supervisor core-side types
// Core output bus, group redundancy mode and the control and event
// bundles exchanged between the register bank and each group
//**************************************************************************

`include "dmr_macros.svh"

package dmr_core_pkg;

  // One core's output bus as seen by the lockstep comparator
  typedef struct packed {
    logic                   valid;
    logic [31:0]            addr;
    logic [`DMR_DATA_W-1:0] data;
  } core_out_t;

  typedef enum logic [1:0] {
    NON_DMR     = 2'd0,
    DMR_RUN     = 2'd1,
    DMR_RESTORE = 2'd2
  } dmr_mode_e;

  // Per-group settings from the register bank
  // force_recovery is a single-cycle pulse
  typedef struct packed {
    logic dmr_enable;
    logic rapid_recovery;
    logic force_recovery;
  } grp_cfg_t;

  // Per-group status back to the register bank
  typedef struct packed {
    logic independent;
    logic incr_mismatch;
  } grp_evt_t;

endpackage

//--- hw/dmr_ctrl_regs.sv
//**************************************************************************
// DMR supervisor register bank
// Holds per-group enable, rapid-recovery and force bits, the saturating
// mismatch counters and the status word behind a valid-strobe port
//**************************************************************************

`timescale 1ns/10ps
`include "dmr_macros.svh"

module dmr_ctrl_regs (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  dmr_reg_pkg::reg_req_t                        reg_req_i,
  output dmr_reg_pkg::reg_rsp_t                        reg_rsp_o,
  output dmr_core_pkg::grp_cfg_t [`DMR_NUM_GROUPS-1:0] grp_cfg_o,
  input  dmr_core_pkg::grp_evt_t [`DMR_NUM_GROUPS-1:0] grp_evt_i
);

  localparam int unsigned cnt_w = `DMR_CNT_W;

  logic                                    wr_en;
  logic [`DMR_NUM_GROUPS-1:0]              enable_q;
  logic [`DMR_NUM_GROUPS-1:0]              rapid_q;
  logic [`DMR_NUM_GROUPS-1:0]              force_q;
  logic [`DMR_NUM_GROUPS-1:0]              mis_sel;
  logic [`DMR_NUM_GROUPS-1:0]              status;
  logic [`DMR_NUM_GROUPS-1:0][cnt_w-1:0]   cnt_q;
  logic [31:0]                             rdata_d;
  logic                                    err_d;
  dmr_reg_pkg::reg_rsp_t                   rsp_q;

  assign wr_en = reg_req_i.valid & reg_req_i.write;

  // Counter address decode, status gather and config fan-out
  always_comb begin
    for (int g = 0; g < `DMR_NUM_GROUPS; g++) begin
      mis_sel[g]   = (4'(reg_req_i.addr) == 4'(dmr_reg_pkg::ADDR_MISMATCH0) + 4'(g));
      status[g]    = grp_evt_i[g].independent;
      grp_cfg_o[g] = '{dmr_enable:     enable_q[g],
                       rapid_recovery: rapid_q[g],
                       force_recovery: force_q[g]};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= '0;
      rapid_q  <= '0;
      force_q  <= '0;
    end else begin
      // Force bits live for one cycle only
      force_q <= '0;
      if (wr_en) begin
        case (reg_req_i.addr)
          dmr_reg_pkg::ADDR_ENABLE: enable_q <= reg_req_i.wdata[`DMR_NUM_GROUPS-1:0];
          dmr_reg_pkg::ADDR_RAPID:  rapid_q  <= reg_req_i.wdata[`DMR_NUM_GROUPS-1:0];
          dmr_reg_pkg::ADDR_FORCE:  force_q  <= reg_req_i.wdata[`DMR_NUM_GROUPS-1:0];
          default: ;
        endcase
      end
    end
  end

  // Saturating mismatch counters, a software clear beats an increment
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int g = 0; g < `DMR_NUM_GROUPS; g++) begin
        if (wr_en && mis_sel[g]) begin
          cnt_q[g] <= '0;
        end else if (grp_evt_i[g].incr_mismatch && (cnt_q[g] != '1)) begin
          cnt_q[g] <= cnt_q[g] + cnt_w'(1);
        end
      end
    end
  end

  // Read mux
  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    case (reg_req_i.addr)
      dmr_reg_pkg::ADDR_ENABLE: rdata_d[`DMR_NUM_GROUPS-1:0] = enable_q;
      dmr_reg_pkg::ADDR_RAPID:  rdata_d[`DMR_NUM_GROUPS-1:0] = rapid_q;
      dmr_reg_pkg::ADDR_FORCE:  rdata_d = '0;
      dmr_reg_pkg::ADDR_STATUS: rdata_d[`DMR_NUM_GROUPS-1:0] = status;
      default: begin
        err_d = ~|mis_sel;
        for (int g = 0; g < `DMR_NUM_GROUPS; g++) begin
          if (mis_sel[g]) begin
            rdata_d[cnt_w-1:0] = cnt_q[g];
          end
        end
      end
    endcase
  end

  // Every access is acknowledged, rdata only carries read results
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_q <= '0;
    end else begin
      rsp_q.rvalid <= reg_req_i.valid;
      rsp_q.rdata  <= (reg_req_i.valid && !reg_req_i.write) ? rdata_d : '0;
      rsp_q.err    <= reg_req_i.valid & err_d;
    end
  end

  assign reg_rsp_o = rsp_q;

  a_addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reg_req_i.valid |-> !$isunknown(reg_req_i.addr))
    else $error("Register address unknown during an access");

endmodule

//--- hw/dmr_lockstep_cmp.sv
//**************************************************************************
// DMR lockstep comparator
// Compares the output buses of the two cores of one group and flags a
// mismatch one cycle later
//**************************************************************************

`timescale 1ns/10ps

module dmr_lockstep_cmp (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  dmr_core_pkg::core_out_t core_a_i,
  input  dmr_core_pkg::core_out_t core_b_i,
  output logic                    dmr_error_o
);

  logic valid_diff;
  logic payload_diff;
  logic mismatch;
  logic dmr_error_q;

  assign valid_diff   = core_a_i.valid ^ core_b_i.valid;
  assign payload_diff = (core_a_i.addr != core_b_i.addr) ||
                        (core_a_i.data != core_b_i.data);

  // Payload only matters when both cores present a transaction
  assign mismatch = valid_diff | (core_a_i.valid & core_b_i.valid & payload_diff);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmr_error_q <= 1'b0;
    end else begin
      dmr_error_q <= mismatch;
    end
  end

  assign dmr_error_o = dmr_error_q;

  a_error_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(dmr_error_o))
    else $error("Lockstep error flag unknown");

endmodule

//--- hw/dmr_group_ctrl.sv
//**************************************************************************
// DMR group mode controller
// Moves one core pair between independent, lockstep and restore modes
// and raises the software and hardware recovery requests
//**************************************************************************

`timescale 1ns/10ps

module dmr_group_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  dmr_core_pkg::grp_cfg_t  cfg_i,
  input  logic                    fetch_en_i,
  input  logic                    cores_synch_i,
  input  dmr_core_pkg::core_out_t core_a_i,
  input  dmr_core_pkg::core_out_t core_b_i,
  input  logic                    recovery_finished_i,
  output dmr_core_pkg::grp_evt_t  evt_o,
  output logic [1:0]              setback_o,
  output logic                    sw_synch_req_o,
  output logic                    sw_resynch_req_o,
  output logic                    recovery_request_o
);

  dmr_core_pkg::dmr_mode_e mode_d;
  dmr_core_pkg::dmr_mode_e mode_q;
  logic                    dmr_error;
  logic                    incr_mismatch;

  dmr_lockstep_cmp i_cmp (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .core_a_i    (core_a_i),
    .core_b_i    (core_b_i),
    .dmr_error_o (dmr_error)
  );

  assign recovery_request_o = (mode_q == dmr_core_pkg::DMR_RESTORE);

  assign evt_o = '{independent:   (mode_q == dmr_core_pkg::NON_DMR),
                   incr_mismatch: incr_mismatch};

  always_comb begin
    mode_d           = mode_q;
    setback_o        = 2'b00;
    sw_synch_req_o   = 1'b0;
    sw_resynch_req_o = 1'b0;
    incr_mismatch    = 1'b0;

    case (mode_q)
      dmr_core_pkg::DMR_RUN: begin
        incr_mismatch = dmr_error;
        if (cfg_i.rapid_recovery) begin
          // Hardware restore on error or on software request
          if (cfg_i.force_recovery || dmr_error) begin
            mode_d = dmr_core_pkg::DMR_RESTORE;
          end
        end else if (dmr_error) begin
          sw_resynch_req_o = 1'b1;
        end
      end
      dmr_core_pkg::DMR_RESTORE: begin
        if (recovery_finished_i) begin
          mode_d = dmr_core_pkg::DMR_RUN;
        end
      end
      default: ;
    endcase

    // Join lockstep once software reports the pair aligned
    if (mode_q == dmr_core_pkg::NON_DMR && cfg_i.dmr_enable) begin
      sw_synch_req_o = 1'b1;
      if (cores_synch_i) begin
        mode_d    = dmr_core_pkg::DMR_RUN;
        setback_o = 2'b11;
      end
    end

    // Before fetch starts the mode simply follows enable
    // A restore already in flight still runs to completion
    if (!fetch_en_i && mode_q != dmr_core_pkg::DMR_RESTORE) begin
      sw_synch_req_o = 1'b0;
      setback_o      = 2'b00;
      mode_d         = cfg_i.dmr_enable ? dmr_core_pkg::DMR_RUN : dmr_core_pkg::NON_DMR;
    end

    // Split back to independent mode
    if (mode_q == dmr_core_pkg::DMR_RUN && !cfg_i.dmr_enable) begin
      mode_d    = dmr_core_pkg::NON_DMR;
      setback_o = 2'b10;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q <= dmr_core_pkg::NON_DMR;
    end else begin
      mode_q <= mode_d;
    end
  end

  // Recovery unit only answers groups that asked for a restore
  a_finish_in_restore: assert property (@(posedge clk_i) disable iff (!rst_ni)
    recovery_finished_i |-> mode_q == dmr_core_pkg::DMR_RESTORE)
    else $error("Recovery finished outside of restore mode");

endmodule

//--- hw/dmr_recovery_unit.sv
//**************************************************************************
// DMR shared recovery unit
// Grants one pending restore at a time, lowest group first, and runs a
// fixed-length restore window for the granted group
//**************************************************************************

`timescale 1ns/10ps
`include "dmr_macros.svh"

module dmr_recovery_unit (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic [`DMR_NUM_GROUPS-1:0] recovery_request_i,
  output logic [`DMR_NUM_GROUPS-1:0] recovery_finished_o,
  output logic [`DMR_NUM_GROUPS-1:0] recovery_active_o
);

  localparam int unsigned      cnt_w      = $clog2(`DMR_RESTORE_CYCLES);
  localparam logic [cnt_w-1:0] last_cycle = cnt_w'(`DMR_RESTORE_CYCLES - 1);

  logic [`DMR_NUM_GROUPS-1:0] grant_q;
  logic [`DMR_NUM_GROUPS-1:0] lowest_req;
  logic [cnt_w-1:0]           cnt_q;
  logic                       busy;
  logic                       last;

  // Two's complement isolates the lowest set request bit
  assign lowest_req = recovery_request_i & (-recovery_request_i);

  assign busy = |grant_q;
  assign last = busy && (cnt_q == last_cycle);

  assign recovery_active_o   = grant_q;
  assign recovery_finished_o = last ? grant_q : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      grant_q <= '0;
      cnt_q   <= '0;
    end else if (!busy) begin
      // Idle, take the highest priority request if any
      grant_q <= lowest_req;
      cnt_q   <= '0;
    end else if (last) begin
      grant_q <= '0;
    end else begin
      cnt_q <= cnt_q + cnt_w'(1);
    end
  end

  a_active_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(recovery_active_o))
    else $error("More than one group in recovery");

endmodule

//--- hw/dmr_subsys_top.sv
//**************************************************************************
// DMR supervisor top level
// Connects the register bank, one mode controller per core pair and the
// shared recovery unit
//**************************************************************************

`timescale 1ns/10ps
`include "dmr_macros.svh"

module dmr_subsys_top (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  dmr_reg_pkg::reg_req_t                         reg_req_i,
  output dmr_reg_pkg::reg_rsp_t                         reg_rsp_o,
  input  logic                                          fetch_en_i,
  input  logic [`DMR_NUM_GROUPS-1:0]                    cores_synch_i,
  input  dmr_core_pkg::core_out_t [`DMR_NUM_GROUPS-1:0] core_a_i,
  input  dmr_core_pkg::core_out_t [`DMR_NUM_GROUPS-1:0] core_b_i,
  output logic [`DMR_NUM_GROUPS-1:0][1:0]               setback_o,
  output logic [`DMR_NUM_GROUPS-1:0]                    sw_synch_req_o,
  output logic [`DMR_NUM_GROUPS-1:0]                    sw_resynch_req_o,
  output logic [`DMR_NUM_GROUPS-1:0]                    grp_in_independent_o,
  output logic [`DMR_NUM_GROUPS-1:0]                    recovery_active_o
);

  dmr_core_pkg::grp_cfg_t [`DMR_NUM_GROUPS-1:0] grp_cfg;
  dmr_core_pkg::grp_evt_t [`DMR_NUM_GROUPS-1:0] grp_evt;
  logic [`DMR_NUM_GROUPS-1:0]                   recovery_request;
  logic [`DMR_NUM_GROUPS-1:0]                   recovery_finished;

  dmr_ctrl_regs i_regs (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .reg_req_i (reg_req_i),
    .reg_rsp_o (reg_rsp_o),
    .grp_cfg_o (grp_cfg),
    .grp_evt_i (grp_evt)
  );

  for (genvar g = 0; g < `DMR_NUM_GROUPS; g++) begin : g_group
    dmr_group_ctrl i_group_ctrl (
      .clk_i               (clk_i),
      .rst_ni              (rst_ni),
      .cfg_i               (grp_cfg[g]),
      .fetch_en_i          (fetch_en_i),
      .cores_synch_i       (cores_synch_i[g]),
      .core_a_i            (core_a_i[g]),
      .core_b_i            (core_b_i[g]),
      .recovery_finished_i (recovery_finished[g]),
      .evt_o               (grp_evt[g]),
      .setback_o           (setback_o[g]),
      .sw_synch_req_o      (sw_synch_req_o[g]),
      .sw_resynch_req_o    (sw_resynch_req_o[g]),
      .recovery_request_o  (recovery_request[g])
    );

    assign grp_in_independent_o[g] = grp_evt[g].independent;
  end

  dmr_recovery_unit i_recovery (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .recovery_request_i  (recovery_request),
    .recovery_finished_o (recovery_finished),
    .recovery_active_o   (recovery_active_o)
  );

endmodule

//--- bench/tb_dmr_subsys.sv
//**************************************************************************
// DMR supervisor testbench
// Directed tests of register access, boot mode, lockstep join and split,
// software resynch and the shared hardware recovery
//**************************************************************************

`timescale 1ns/10ps
`include "dmr_macros.svh"

module tb_dmr_subsys;

  // Whole run is a few hundred cycles
  localparam int max_cycles = 2000;
  localparam int wait_limit = 50;
  localparam logic [31:0] all_groups = 32'({`DMR_NUM_GROUPS{1'b1}});

  logic                                          clk_i;
  logic                                          rst_ni;
  dmr_reg_pkg::reg_req_t                         reg_req;
  dmr_reg_pkg::reg_rsp_t                         reg_rsp;
  logic                                          fetch_en;
  logic [`DMR_NUM_GROUPS-1:0]                    cores_synch;
  dmr_core_pkg::core_out_t [`DMR_NUM_GROUPS-1:0] core_a;
  dmr_core_pkg::core_out_t [`DMR_NUM_GROUPS-1:0] core_b;
  logic [`DMR_NUM_GROUPS-1:0][1:0]               setback;
  logic [`DMR_NUM_GROUPS-1:0]                    sw_synch_req;
  logic [`DMR_NUM_GROUPS-1:0]                    sw_resynch_req;
  logic [`DMR_NUM_GROUPS-1:0]                    independent;
  logic [`DMR_NUM_GROUPS-1:0]                    recovery_active;
  logic [`DMR_NUM_GROUPS-1:0]                    en_shadow;
  int                                            cycle_cnt = 0;

  dmr_subsys_top i_dut (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .reg_req_i            (reg_req),
    .reg_rsp_o            (reg_rsp),
    .fetch_en_i           (fetch_en),
    .cores_synch_i        (cores_synch),
    .core_a_i             (core_a),
    .core_b_i             (core_b),
    .setback_o            (setback),
    .sw_synch_req_o       (sw_synch_req),
    .sw_resynch_req_o     (sw_resynch_req),
    .grp_in_independent_o (independent),
    .recovery_active_o    (recovery_active)
  );

  always #4 clk_i = ~clk_i;

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= max_cycles) begin
      stop_with_error($sformatf("Run did not finish within %0d cycles", max_cycles));
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp)
      else stop_with_error($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h",
                                     name, got, exp));
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else stop_with_error(what);
  endtask

  // Register port with the request in one cycle and the response in the next
  task automatic reg_write(input logic [3:0] addr, input logic [31:0] wdata);
    @(posedge clk_i);
    #1;
    reg_req = '{valid: 1'b1, write: 1'b1, addr: dmr_reg_pkg::reg_addr_e'(addr),
                wdata: wdata};
    @(posedge clk_i);
    #1;
    reg_req = '0;
  endtask

  task automatic reg_read(input logic [3:0] addr, output logic [31:0] rdata,
                          output logic err);
    @(posedge clk_i);
    #1;
    reg_req = '{valid: 1'b1, write: 1'b0, addr: dmr_reg_pkg::reg_addr_e'(addr),
                wdata: 32'h0};
    @(posedge clk_i);
    #1;
    reg_req = '0;
    check_true(reg_rsp.rvalid, "Register read got no rvalid");
    rdata = reg_rsp.rdata;
    err   = reg_rsp.err;
  endtask

  task automatic read_check(input logic [3:0] addr, input logic [31:0] exp,
                            input string name);
    logic [31:0] rdata;
    logic        err;
    reg_read(addr, rdata, err);
    check_value(name, rdata, exp);
    check_value({name, " err"}, 32'(err), 32'h0);
  endtask

  // Identical random buses on both cores of every group
  task automatic load_random_buses();
    for (int g = 0; g < `DMR_NUM_GROUPS; g++) begin
      core_a[g].valid = 1'b1;
      core_a[g].addr  = $urandom;
      core_a[g].data  = `DMR_DATA_W'($urandom);
    end
    core_b = core_a;
  endtask

  // Flip one data bit of core B for one cycle in every group of the mask
  task automatic inject_mismatch(input logic [3:0] mask);
    int bit_idx;
    @(posedge clk_i);
    #1;
    load_random_buses();
    bit_idx = int'($urandom % 32'(`DMR_DATA_W));
    for (int g = 0; g < `DMR_NUM_GROUPS; g++) begin
      if (mask[g]) core_b[g].data[bit_idx] = ~core_b[g].data[bit_idx];
    end
    @(posedge clk_i);
    #1;
    core_b = core_a;
  endtask

  task automatic join_lockstep(input int g);
    int n;
    en_shadow[g] = 1'b1;
    reg_write(4'(dmr_reg_pkg::ADDR_ENABLE), 32'(en_shadow));
    n = 0;
    @(negedge clk_i);
    while (!sw_synch_req[g] && n < wait_limit) begin
      @(negedge clk_i);
      n++;
    end
    check_true(n < wait_limit, $sformatf("Group %0d never requested a sync", g));
    // Request holds until the pair reports alignment
    repeat (3) begin
      @(negedge clk_i);
      check_value($sformatf("sw_synch_req_o[%0d]", g), 32'(sw_synch_req[g]), 32'h1);
      check_value($sformatf("grp_in_independent_o[%0d]", g), 32'(independent[g]), 32'h1);
    end
    @(posedge clk_i);
    #1;
    cores_synch[g] = 1'b1;
    @(negedge clk_i);
    check_value($sformatf("setback_o[%0d]", g), 32'(setback[g]), 32'h3);
    @(posedge clk_i);
    #1;
    cores_synch[g] = 1'b0;
    @(negedge clk_i);
    check_value($sformatf("setback_o[%0d]", g), 32'(setback[g]), 32'h0);
    check_value($sformatf("grp_in_independent_o[%0d]", g), 32'(independent[g]), 32'h0);
    check_value($sformatf("sw_synch_req_o[%0d]", g), 32'(sw_synch_req[g]), 32'h0);
  endtask

  // Waits for the next restore window and checks its owner and length
  task automatic measure_window(input logic [3:0] exp_mask);
    int n;
    int len;
    n = 0;
    @(negedge clk_i);
    while (recovery_active == '0 && n < wait_limit) begin
      @(negedge clk_i);
      n++;
    end
    check_true(n < wait_limit, "No restore window started");
    check_value("recovery_active_o", 32'(recovery_active), 32'(exp_mask));
    len = 0;
    while (recovery_active == exp_mask && len <= `DMR_RESTORE_CYCLES) begin
      len++;
      @(negedge clk_i);
    end
    check_value("recovery_active_o cycles", 32'(len), 32'(`DMR_RESTORE_CYCLES));
  endtask

  task automatic test_reset_and_regs();
    logic [31:0] rdata;
    logic        err;
    check_value("grp_in_independent_o", 32'(independent), all_groups);
    check_value("recovery_active_o", 32'(recovery_active), 32'h0);
    read_check(4'(dmr_reg_pkg::ADDR_STATUS), all_groups, "STATUS");
    reg_write(4'(dmr_reg_pkg::ADDR_ENABLE), 32'hA);
    read_check(4'(dmr_reg_pkg::ADDR_ENABLE), 32'hA, "ENABLE");
    reg_write(4'(dmr_reg_pkg::ADDR_RAPID), 32'h5);
    read_check(4'(dmr_reg_pkg::ADDR_RAPID), 32'h5, "RAPID");
    // Force is a pulse and reads as zero even with its neighbours set
    reg_write(4'(dmr_reg_pkg::ADDR_FORCE), all_groups);
    read_check(4'(dmr_reg_pkg::ADDR_FORCE), 32'h0, "FORCE");
    reg_write(4'(dmr_reg_pkg::ADDR_ENABLE), 32'h0);
    reg_write(4'(dmr_reg_pkg::ADDR_RAPID), 32'h0);
    reg_read(4'd9, rdata, err);
    check_value("reg_rsp_o.err", 32'(err), 32'h1);
  endtask

  // Fetch is low here, so the mode follows the enable bit
  task automatic test_boot_mode();
    int n;
    en_shadow = 4'b0001;
    reg_write(4'(dmr_reg_pkg::ADDR_ENABLE), 32'(en_shadow));
    n = 0;
    while (independent[0] && n < wait_limit) begin
      @(negedge clk_i);
      check_value("sw_synch_req_o", 32'(sw_synch_req), 32'h0);
      n++;
    end
    check_true(n < wait_limit, "Group 0 did not leave independent mode at boot");
    en_shadow = '0;
    reg_write(4'(dmr_reg_pkg::ADDR_ENABLE), 32'(en_shadow));
    @(negedge clk_i);
    @(negedge clk_i);
    check_value("grp_in_independent_o", 32'(independent), all_groups);
  endtask

  task automatic test_join_split();
    @(posedge clk_i);
    #1;
    fetch_en = 1'b1;
    join_lockstep(1);
    read_check(4'(dmr_reg_pkg::ADDR_STATUS), 32'hD, "STATUS");
    en_shadow[1] = 1'b0;
    reg_write(4'(dmr_reg_pkg::ADDR_ENABLE), 32'(en_shadow));
    @(negedge clk_i);
    check_value("setback_o[1]", 32'(setback[1]), 32'h2);
    @(negedge clk_i);
    check_value("setback_o[1]", 32'(setback[1]), 32'h0);
    check_value("grp_in_independent_o", 32'(independent), all_groups);
  endtask

  task automatic test_sw_resynch();
    join_lockstep(2);
    inject_mismatch(4'b0100);
    @(negedge clk_i);
    check_value("sw_resynch_req_o", 32'(sw_resynch_req), 32'h4);
    @(negedge clk_i);
    check_value("sw_resynch_req_o", 32'(sw_resynch_req), 32'h0);
    check_value("grp_in_independent_o[2]", 32'(independent[2]), 32'h0);
    read_check(4'(dmr_reg_pkg::ADDR_MISMATCH2), 32'h1, "MISMATCH2");
    reg_write(4'(dmr_reg_pkg::ADDR_MISMATCH2), 32'h0);
    read_check(4'(dmr_reg_pkg::ADDR_MISMATCH2), 32'h0, "MISMATCH2");
  endtask

  task automatic test_hw_recovery();
    join_lockstep(1);
    reg_write(4'(dmr_reg_pkg::ADDR_RAPID), 32'h6);
    inject_mismatch(4'b0110);
    measure_window(4'b0010);
    measure_window(4'b0100);
    read_check(4'(dmr_reg_pkg::ADDR_STATUS), 32'h9, "STATUS");
    read_check(4'(dmr_reg_pkg::ADDR_MISMATCH1), 32'h1, "MISMATCH1");
    read_check(4'(dmr_reg_pkg::ADDR_MISMATCH2), 32'h1, "MISMATCH2");
  endtask

  task automatic test_forced_recovery();
    join_lockstep(0);
    reg_write(4'(dmr_reg_pkg::ADDR_RAPID), 32'h7);
    reg_write(4'(dmr_reg_pkg::ADDR_FORCE), 32'h1);
    measure_window(4'b0001);
    read_check(4'(dmr_reg_pkg::ADDR_MISMATCH0), 32'h0, "MISMATCH0");
    read_check(4'(dmr_reg_pkg::ADDR_STATUS), 32'h8, "STATUS");
  endtask

  initial begin
    void'($urandom(32'he7770a87));
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    reg_req     = '0;
    fetch_en    = 1'b0;
    cores_synch = '0;
    en_shadow   = '0;
    load_random_buses();
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    test_reset_and_regs();
    test_boot_mode();
    test_join_split();
    test_sw_resynch();
    test_hw_recovery();
    test_forced_recovery();
    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- files.f
+incdir+hw
hw/dmr_reg_pkg.sv
hw/dmr_core_pkg.sv
hw/dmr_ctrl_regs.sv
hw/dmr_lockstep_cmp.sv
hw/dmr_group_ctrl.sv
hw/dmr_recovery_unit.sv
hw/dmr_subsys_top.sv
bench/tb_dmr_subsys.sv

//--- Makefile
TOP := tb_dmr_subsys

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): files.f $(wildcard hw/*.sv hw/*.svh bench/*.sv)
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing --assert -f files.f --top-module $(TOP)

clean:
	rm -rf obj_dir
